// File: verification/hbmc_cases.txt
# op addr len-1 seed (hex); op 0 write, 1 partial-strobe write, 2 read
# op 3 read with RREADY gaps, 4 write with late BREADY, 5 write plus read of previous write
0 000 0 01
2 000 0 00
0 010 f 02
2 010 f 00
0 100 7 03
1 102 7 04
2 101 7 00
4 200 3 05
3 200 3 00
0 300 f 06
3 300 f 00
4 400 a 07
5 500 5 08
2 500 5 00
0 ffc 1 09
2 ffc 1 00

// File: flist.f
+incdir+verilog
verilog/hbmc_pkg.sv
verilog/hbmc_cmd_if.sv
verilog/hbmc_xfer_arbiter.sv
verilog/hbmc_sync_fifo.sv
verilog/hbmc_word_engine.sv
verilog/hbmc_axi_top.sv
verification/hbmc_tb_props.sv
verification/hbmc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module hbmc_tb \
    -o Vhbmc_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/Vhbmc_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
grep -q "Testbench passed" sim.log || exit 1
exit 0

// File: verification/hbmc_tb.sv
/* transfers come from verification/hbmc_cases.txt relative to the project root
   reads must only cover byte ranges that earlier cases wrote */
`default_nettype none
`timescale 1ns/1ps

`include "hbmc_defines.svh"

module hbmc_tb;

    logic                    clk;
    logic                    rstn;
    logic [`HBMC_ID_W-1:0]   awid, arid;
    logic [`HBMC_ADDR_W-1:0] awaddr, araddr;
    logic [7:0]              awlen, arlen;
    logic [2:0]              awsize, arsize;
    logic [1:0]              awburst, arburst;
    logic                    awvalid, arvalid, wlast, wvalid, bready, rready;
    logic [`HBMC_DATA_W-1:0] wdata;
    logic [`HBMC_STRB_W-1:0] wstrb;
    wire                     awready, arready, wready, bvalid, rlast, rvalid;
    wire  [`HBMC_ID_W-1:0]   bid, rid;
    wire  [1:0]              bresp, rresp;
    wire  [`HBMC_DATA_W-1:0] rdata;

    logic [7:0]  ref_mem [4096];   // byte image of the DUT memory
    logic [31:0] case_op [$];
    logic [31:0] case_addr [$];
    logic [31:0] case_len [$];
    logic [31:0] case_seed [$];
    logic [31:0] rng;
    logic [11:0] prev_waddr;
    logic [3:0]  prev_wlen;
    bit          loaded;
    string       line;
    int          fd, code, n;
    logic [31:0] f_op, f_addr, f_len, f_seed;

    hbmc_axi_top hbmc_axi_top_inst (
        .s_axi_aclk(clk), .s_axi_aresetn(rstn),
        .s_axi_awid(awid), .s_axi_awaddr(awaddr), .s_axi_awlen(awlen),
        .s_axi_awsize(awsize), .s_axi_awburst(awburst), .s_axi_awvalid(awvalid),
        .s_axi_awready(awready), .s_axi_wdata(wdata), .s_axi_wstrb(wstrb),
        .s_axi_wlast(wlast), .s_axi_wvalid(wvalid), .s_axi_wready(wready),
        .s_axi_bid(bid), .s_axi_bresp(bresp), .s_axi_bvalid(bvalid), .s_axi_bready(bready),
        .s_axi_arid(arid), .s_axi_araddr(araddr), .s_axi_arlen(arlen),
        .s_axi_arsize(arsize), .s_axi_arburst(arburst), .s_axi_arvalid(arvalid),
        .s_axi_arready(arready), .s_axi_rid(rid), .s_axi_rdata(rdata), .s_axi_rresp(rresp),
        .s_axi_rlast(rlast), .s_axi_rvalid(rvalid), .s_axi_rready(rready)
    );

    bind hbmc_axi_top hbmc_tb_props hbmc_tb_props_inst (
        .s_axi_aclk(s_axi_aclk), .s_axi_aresetn(s_axi_aresetn),
        .s_axi_awready(s_axi_awready), .s_axi_arready(s_axi_arready),
        .s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
        .s_axi_rvalid(s_axi_rvalid), .s_axi_rready(s_axi_rready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 32-bit word from the byte image with 4 KiB wrap
    function automatic logic [31:0] ref_word(input logic [11:0] base);
        logic [31:0] w;
        logic [11:0] p;
        for (int k = 0; k < 4; k++) begin
            p = base + 12'(k);
            w[8*k +: 8] = ref_mem[p];
        end
        return w;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            $display("Testbench failed");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic write_burst(input logic [11:0] addr, input logic [3:0] len,
                               input logic [31:0] seed, input bit partial, input bit slow_b,
                               input logic [3:0] id);
        logic [31:0] st;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [11:0] p;
        int          delay;
        st = 32'he6ec_3505 ^ seed;
        @(posedge clk);
        awid    <= id;
        awaddr  <= addr;
        awlen   <= {4'h0, len};
        awvalid <= 1'b1;   // held until the data burst is in
        for (int i = 0; i <= int'(len); i++) begin
            st   = lcg_next(st);
            data = st;
            st   = lcg_next(st);
            strb = partial ? st[31:28] : 4'hf;
            wdata  <= data;
            wstrb  <= strb;
            wlast  <= (i == int'(len));
            wvalid <= 1'b1;
            for (int k = 0; k < 4; k++) begin
                p = {addr[11:2], 2'b00} + 12'(4 * i + k);
                if (strb[k]) ref_mem[p] = data[8*k +: 8];
            end
            do @(negedge clk); while (!wready);
            @(posedge clk);
        end
        wvalid <= 1'b0;
        wlast  <= 1'b0;
        do @(negedge clk); while (!awready);
        @(posedge clk);
        awvalid <= 1'b0;
        delay = slow_b ? int'(rng[31:29]) + 1 : 0;
        if (!slow_b) bready <= 1'b1;
        do @(negedge clk); while (!bvalid);
        repeat (delay) begin
            @(negedge clk);
            check("bvalid", 32'd1, {31'd0, bvalid});   // must wait for BREADY
        end
        if (slow_b) begin
            @(posedge clk);
            bready <= 1'b1;
            @(negedge clk);
        end
        check("bid", {28'd0, id}, {28'd0, bid});
        check("bresp", 32'd0, {30'd0, bresp});
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic read_burst(input logic [11:0] addr, input logic [3:0] len,
                              input bit bp, input logic [3:0] id);
        int beat;
        bit done;
        beat = 0;
        done = 0;
        @(posedge clk);
        arid    <= id;
        araddr  <= addr;
        arlen   <= {4'h0, len};
        arvalid <= 1'b1;
        rready  <= 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        while (!done) begin
            @(negedge clk);
            if (rvalid && rready) begin
                check("rdata", ref_word({addr[11:2], 2'b00} + 12'(4 * beat)), rdata);
                check("rlast", {31'd0, beat == int'(len)}, {31'd0, rlast});
                check("rid", {28'd0, id}, {28'd0, rid});
                check("rresp", 32'd0, {30'd0, rresp});
                done = rlast;
                beat++;
            end
            @(posedge clk);
            rng = lcg_next(rng);
            rready <= bp ? (rng[31:29] > 3'd3) : 1'b1;   // low stretches fill the FIFO
        end
        rready <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        wait (loaded);
        repeat (n * 200 + 20) @(posedge clk);
        $display("ERROR: watchdog expired, a transfer did not complete");
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

    initial begin
        forever begin
            @(negedge clk);
            if (rstn) check("awready_and_arready", 32'd0, {31'd0, awready & arready});
        end
    end

    initial begin
        rstn = 1'b0;
        {awid, arid, awaddr, araddr, awlen, arlen} = '0;
        {awvalid, arvalid, wvalid, wlast, bready, rready} = '0;
        wdata   = '0;
        wstrb   = '0;
        awsize  = 3'd2;
        arsize  = 3'd2;
        awburst = 2'b01;
        arburst = 2'b01;
        rng     = 32'he6ec_3505;
        fd = $fopen("verification/hbmc_cases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open verification/hbmc_cases.txt");
            $display("Testbench failed");
            $fatal(1, "no case file");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code != 0
                    && $sscanf(line, "%h %h %h %h", f_op, f_addr, f_len, f_seed) == 4) begin
                case_op.push_back(f_op);
                case_addr.push_back(f_addr);
                case_len.push_back(f_len);
                case_seed.push_back(f_seed);
            end
        end
        $fclose(fd);
        n = case_op.size();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check("awready", 32'd0, {31'd0, awready});
        check("arready", 32'd0, {31'd0, arready});
        check("bvalid", 32'd0, {31'd0, bvalid});
        check("rvalid", 32'd0, {31'd0, rvalid});
        check("wready", 32'd1, {31'd0, wready});
        for (int i = 0; i < n; i++) begin
            case (case_op[i])
                0, 1, 4: write_burst(case_addr[i][11:0], case_len[i][3:0], case_seed[i],
                                     case_op[i] == 1, case_op[i] == 4, 4'(i));
                2, 3: read_burst(case_addr[i][11:0], case_len[i][3:0], case_op[i] == 3, 4'(i));
                default: begin   // write and read raised in the same cycle
                    fork
                        write_burst(case_addr[i][11:0], case_len[i][3:0], case_seed[i],
                                    1'b0, 1'b0, 4'(i));
                        read_burst(prev_waddr, prev_wlen, 1'b0, 4'(i + 1));
                    join
                end
            endcase
            if (case_op[i] == 0 || case_op[i] == 1 || case_op[i] == 4) begin
                prev_waddr = case_addr[i][11:0];
                prev_wlen  = case_len[i][3:0];
            end
        end
        repeat (4) @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/hbmc_tb_props.sv
/* handshake rules of the AXI slave ports, checked only out of reset */
`default_nettype none
`timescale 1ns/1ps

module hbmc_tb_props (
    input wire logic s_axi_aclk,
    input wire logic s_axi_aresetn,
    input wire logic s_axi_awready,
    input wire logic s_axi_arready,
    input wire logic s_axi_bvalid,
    input wire logic s_axi_bready,
    input wire logic s_axi_rvalid,
    input wire logic s_axi_rready
);

    a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else $error("BVALID dropped before BREADY");

    a_addr_ready_excl: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        !(s_axi_awready && s_axi_arready))
        else $error("AWREADY and ARREADY high together");

    a_rvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
        else $error("RVALID dropped before RREADY");

endmodule

`default_nettype wire

// File: verilog/hbmc_axi_top.sv
/* AXI4 slave, INCR bursts up to 16 beats; AxSIZE and AxBURST are ignored
   send the write data burst before or with AWVALID */
`default_nettype none
`timescale 1ns/1ps

`include "hbmc_defines.svh"

module hbmc_axi_top (
    input  logic                    s_axi_aclk,
    input  logic                    s_axi_aresetn,
    input  logic [`HBMC_ID_W-1:0]   s_axi_awid,
    input  logic [`HBMC_ADDR_W-1:0] s_axi_awaddr,
    input  logic [7:0]              s_axi_awlen,     // only 3:0 honoured
    input  logic [2:0]              s_axi_awsize,    // unused
    input  logic [1:0]              s_axi_awburst,   // unused
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,
    input  logic [`HBMC_DATA_W-1:0] s_axi_wdata,
    input  logic [`HBMC_STRB_W-1:0] s_axi_wstrb,
    input  logic                    s_axi_wlast,
    input  logic                    s_axi_wvalid,
    output logic                    s_axi_wready,
    output logic [`HBMC_ID_W-1:0]   s_axi_bid,
    output logic [1:0]              s_axi_bresp,
    output logic                    s_axi_bvalid,
    input  logic                    s_axi_bready,
    input  logic [`HBMC_ID_W-1:0]   s_axi_arid,
    input  logic [`HBMC_ADDR_W-1:0] s_axi_araddr,
    input  logic [7:0]              s_axi_arlen,     // only 3:0 honoured
    input  logic [2:0]              s_axi_arsize,    // unused
    input  logic [1:0]              s_axi_arburst,   // unused
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,
    output logic [`HBMC_ID_W-1:0]   s_axi_rid,
    output logic [`HBMC_DATA_W-1:0] s_axi_rdata,
    output logic [1:0]              s_axi_rresp,
    output logic                    s_axi_rlast,
    output logic                    s_axi_rvalid,
    input  logic                    s_axi_rready
);

    import hbmc_pkg::*;

    wdata_entry_t          wf_din;
    wdata_entry_t          wf_dout;
    rdata_entry_t          rf_din;
    rdata_entry_t          rf_dout;
    logic                  wf_pop;
    logic                  wf_full;
    logic                  wf_empty;
    logic                  rf_push;
    logic                  rf_full;
    logic                  rf_empty;
    logic                  wr_done;
    logic [`HBMC_ID_W-1:0] xfer_id;

    hbmc_cmd_if cmd_if_inst ();

    assign wf_din       = '{data: s_axi_wdata, strb: s_axi_wstrb};
    assign s_axi_wready = ~wf_full;
    assign s_axi_rvalid = ~rf_empty;
    assign s_axi_rdata  = rf_dout.data;
    assign s_axi_rlast  = rf_dout.last;
    assign s_axi_rid    = xfer_id;
    assign s_axi_bid    = xfer_id;
    assign s_axi_rresp  = OKAY;
    assign s_axi_bresp  = OKAY;

    hbmc_xfer_arbiter hbmc_xfer_arbiter_inst (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .awid          (s_axi_awid),
        .arid          (s_axi_arid),
        .awaddr        (s_axi_awaddr),
        .araddr        (s_axi_araddr),
        .awlen         (s_axi_awlen[3:0]),
        .arlen         (s_axi_arlen[3:0]),
        .awvalid       (s_axi_awvalid),
        .arvalid       (s_axi_arvalid),
        .wlast_hs      (s_axi_wvalid & s_axi_wready & s_axi_wlast),
        .rlast_hs      (s_axi_rvalid & s_axi_rready & s_axi_rlast),
        .bready        (s_axi_bready),
        .wr_done       (wr_done),
        .awready       (s_axi_awready),
        .arready       (s_axi_arready),
        .bvalid        (s_axi_bvalid),
        .xfer_id       (xfer_id),
        .cmd           (cmd_if_inst.arbiter)
    );

    hbmc_sync_fifo #(
        .payload_t (wdata_entry_t)
    ) hbmc_wfifo_inst (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .push          (s_axi_wvalid & s_axi_wready),
        .din           (wf_din),
        .pop           (wf_pop),
        .dout          (wf_dout),
        .full          (wf_full),
        .empty         (wf_empty)
    );

    hbmc_sync_fifo #(
        .payload_t (rdata_entry_t)
    ) hbmc_rfifo_inst (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .push          (rf_push),
        .din           (rf_din),
        .pop           (s_axi_rvalid & s_axi_rready),
        .dout          (rf_dout),
        .full          (rf_full),
        .empty         (rf_empty)
    );

    hbmc_word_engine hbmc_word_engine_inst (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .cmd           (cmd_if_inst.engine),
        .wf_dout       (wf_dout),
        .wf_empty      (wf_empty),
        .wf_pop        (wf_pop),
        .rf_din        (rf_din),
        .rf_full       (rf_full),
        .rf_push       (rf_push),
        .wr_done       (wr_done)
    );

endmodule

`default_nettype wire

// File: verilog/hbmc_word_engine.sv
/* stands in for the HyperBus controller; command address must be even
   memory content is undefined until written */
`default_nettype none
`timescale 1ns/1ps

`include "hbmc_defines.svh"

module hbmc_word_engine (
    input  logic                   s_axi_aclk,
    input  logic                   s_axi_aresetn,
    hbmc_cmd_if.engine             cmd,
    input  hbmc_pkg::wdata_entry_t wf_dout,
    input  logic                   wf_empty,
    output logic                   wf_pop,
    output hbmc_pkg::rdata_entry_t rf_din,
    input  logic                   rf_full,
    output logic                   rf_push,
    output logic                   wr_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ
    } state_t;

    state_t                       state;
    logic [15:0]                  mem [`HBMC_MEM_WORDS];
    logic [`HBMC_WORD_ADDR_W-1:0] addr;   // wraps modulo memory size
    logic [`HBMC_CNT_W-1:0]       cnt;    // words left
    logic                         half;   // 1 on the odd word of a beat
    logic [15:0]                  lo_word;
    logic [15:0]                  wr_word;
    logic [1:0]                   wr_strb;
    logic                         wr_step;
    logic                         rd_step;
    logic                         last_word;

    assign wr_step   = (state == ST_WRITE) && !wf_empty;
    assign rd_step   = (state == ST_READ) && !(half && rf_full);   // stall on full FIFO
    assign last_word = (cnt == 1);

    assign wr_word = half ? wf_dout.data[31:16] : wf_dout.data[15:0];
    assign wr_strb = half ? wf_dout.strb[3:2] : wf_dout.strb[1:0];
    assign wf_pop  = wr_step & half;   // beat fully consumed

    assign rf_din.data = {mem[addr], lo_word};
    assign rf_din.last = last_word;
    assign rf_push     = rd_step & half;

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            state   <= ST_IDLE;
            cmd.ack <= 1'b0;
            addr    <= '0;
            cnt     <= '0;
            half    <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= wr_step & last_word;
            if (!cmd.ack && cmd.req && state == ST_IDLE) begin
                cmd.ack <= 1'b1;   // fields latched here
                addr    <= cmd.word_addr;
                cnt     <= cmd.word_cnt;
                half    <= 1'b0;
                state   <= cmd.wr_not_rd ? ST_WRITE : ST_READ;
            end else if (cmd.ack && !cmd.req) begin
                cmd.ack <= 1'b0;
            end
            if (wr_step || rd_step) begin
                addr <= addr + 1'b1;
                cnt  <= cnt - 1'b1;
                half <= ~half;
                if (last_word) begin
                    state <= ST_IDLE;
                end
            end
        end
    end

    // byte-granular word writes, low word kept for read pairing
    always_ff @(posedge s_axi_aclk) begin
        if (wr_step) begin
            if (wr_strb[0]) begin
                mem[addr][7:0] <= wr_word[7:0];
            end
            if (wr_strb[1]) begin
                mem[addr][15:8] <= wr_word[15:8];
            end
        end
        if (rd_step && !half) begin
            lo_word <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/hbmc_sync_fifo.sv
/* first-word-fall-through; dout is valid while empty is low
   push on full and pop on empty are ignored */
`default_nettype none
`timescale 1ns/1ps

`include "hbmc_defines.svh"

module hbmc_sync_fifo #(
    parameter type payload_t = logic [`HBMC_DATA_W-1:0]
) (
    input  logic     s_axi_aclk,
    input  logic     s_axi_aresetn,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     full,
    output logic     empty
);

    localparam int DEPTH = `HBMC_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    payload_t         buffer [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign full    = (count == DEPTH);
    assign empty   = (count == 0);
    assign dout    = buffer[rd_ptr];

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (do_push) begin
            buffer[wr_ptr] <= din;
        end
    end

endmodule

`default_nettype wire

// File: verilog/hbmc_xfer_arbiter.sv
/* write address is taken only after the whole data burst is in the FIFO
   one write in flight; next burst's WLAST should follow the B handshake */
`default_nettype none
`timescale 1ns/1ps

`include "hbmc_defines.svh"

module hbmc_xfer_arbiter (
    input  logic                   s_axi_aclk,
    input  logic                   s_axi_aresetn,
    input  logic [`HBMC_ID_W-1:0]  awid,
    input  logic [`HBMC_ID_W-1:0]  arid,
    input  logic [`HBMC_ADDR_W-1:0] awaddr,
    input  logic [`HBMC_ADDR_W-1:0] araddr,
    input  logic [3:0]             awlen,
    input  logic [3:0]             arlen,
    input  logic                   awvalid,
    input  logic                   arvalid,
    input  logic                   wlast_hs,
    input  logic                   rlast_hs,
    input  logic                   bready,
    input  logic                   wr_done,
    output logic                   awready,
    output logic                   arready,
    output logic                   bvalid,
    output logic [`HBMC_ID_W-1:0]  xfer_id,
    hbmc_cmd_if.arbiter            cmd
);

    typedef enum logic [2:0] {
        ST_RST,
        ST_XFER_SEL,
        ST_XFER_INIT,
        ST_WAIT_START,
        ST_WAIT_COMPLETE
    } state_t;

    typedef enum logic {
        ST_BRESP_IDLE,
        ST_BRESP_SEND
    } bresp_state_t;

    state_t       state;
    bresp_state_t bresp_state;
    logic         wr_addr_done;
    logic         wr_data_done;
    logic         wr_xfer_done;
    logic         rd_xfer_done;
    logic         wr_cond;
    logic         rd_cond;
    logic         pick_wr;

    assign wr_cond = awvalid & wr_data_done;   // data burst already buffered
    assign rd_cond = arvalid & rd_xfer_done;   // no read outstanding
    assign pick_wr = wr_cond & (~rd_cond | ~cmd.wr_not_rd);   // alternate on a tie

    // main transfer FSM
    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            state         <= ST_RST;
            cmd.req       <= 1'b0;
            cmd.wr_not_rd <= 1'b0;
            cmd.word_addr <= '0;
            cmd.word_cnt  <= '0;
            awready       <= 1'b0;
            arready       <= 1'b0;
            xfer_id       <= '0;
        end else begin
            case (state)
                ST_RST: begin
                    cmd.req <= 1'b0;
                    state   <= ST_XFER_SEL;
                end
                ST_XFER_SEL: begin
                    if (pick_wr) begin
                        awready       <= 1'b1;
                        xfer_id       <= awid;
                        cmd.wr_not_rd <= 1'b1;
                        cmd.word_addr <= {awaddr[`HBMC_ADDR_W-1:2], 1'b0};   // aligned, /2
                        cmd.word_cnt  <= {({1'b0, awlen} + 5'd1), 1'b0};     // 2 words per beat
                        state         <= ST_XFER_INIT;
                    end else if (rd_cond) begin
                        arready       <= 1'b1;
                        xfer_id       <= arid;
                        cmd.wr_not_rd <= 1'b0;
                        cmd.word_addr <= {araddr[`HBMC_ADDR_W-1:2], 1'b0};
                        cmd.word_cnt  <= {({1'b0, arlen} + 5'd1), 1'b0};
                        state         <= ST_XFER_INIT;
                    end
                end
                ST_XFER_INIT: begin
                    awready <= 1'b0;
                    arready <= 1'b0;
                    if (!cmd.ack) begin
                        cmd.req <= 1'b1;
                        state   <= ST_WAIT_START;
                    end
                end
                ST_WAIT_START: begin
                    if (cmd.ack) begin
                        cmd.req <= 1'b0;
                        state   <= ST_WAIT_COMPLETE;
                    end
                end
                ST_WAIT_COMPLETE: begin
                    if (cmd.wr_not_rd ? wr_xfer_done : rd_xfer_done) begin
                        state <= ST_XFER_SEL;
                    end
                end
                default: state <= ST_RST;
            endcase
        end
    end

    // read is outstanding from ARREADY until the RLAST handshake
    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            rd_xfer_done <= 1'b1;
        end else if (rlast_hs) begin
            rd_xfer_done <= 1'b1;
        end else if (arvalid && arready) begin
            rd_xfer_done <= 1'b0;
        end
    end

    // write response FSM
    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            wr_addr_done <= 1'b0;
            wr_data_done <= 1'b0;
            wr_xfer_done <= 1'b1;
            bvalid       <= 1'b0;
            bresp_state  <= ST_BRESP_IDLE;
        end else begin
            case (bresp_state)
                ST_BRESP_IDLE: begin
                    if (awvalid && awready) begin
                        wr_addr_done <= 1'b1;
                        wr_xfer_done <= 1'b0;
                    end
                    if (wlast_hs) begin
                        wr_data_done <= 1'b1;
                    end
                    if (wr_addr_done && wr_data_done && wr_done) begin   // engine finished
                        bvalid      <= 1'b1;
                        bresp_state <= ST_BRESP_SEND;
                    end
                end
                ST_BRESP_SEND: begin
                    if (bready) begin
                        wr_addr_done <= 1'b0;
                        wr_data_done <= wlast_hs;   // keep a WLAST landing on this edge
                        wr_xfer_done <= 1'b1;
                        bvalid       <= 1'b0;
                        bresp_state  <= ST_BRESP_IDLE;
                    end
                end
                default: bresp_state <= ST_BRESP_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/hbmc_cmd_if.sv
/* four-phase req/ack command channel; fields must hold while req is high
   end of transfer is not reported here */
`default_nettype none
`timescale 1ns/1ps

`include "hbmc_defines.svh"

interface hbmc_cmd_if;

    logic                         req;
    logic                         ack;
    logic [`HBMC_WORD_ADDR_W-1:0] word_addr;   // 16-bit word address
    logic [`HBMC_CNT_W-1:0]       word_cnt;    // number of 16-bit words
    logic                         wr_not_rd;

    modport arbiter (
        output req,
        output word_addr,
        output word_cnt,
        output wr_not_rd,
        input  ack
    );

    modport engine (
        input  req,
        input  word_addr,
        input  word_cnt,
        input  wr_not_rd,
        output ack
    );

endinterface

`default_nettype wire

// File: verilog/hbmc_pkg.sv
/* FIFO payload layouts and AXI response code */
`default_nettype none

`include "hbmc_defines.svh"

package hbmc_pkg;

    // one write beat as stored in the write FIFO
    typedef struct packed {
        logic [`HBMC_DATA_W-1:0] data;
        logic [`HBMC_STRB_W-1:0] strb;
    } wdata_entry_t;

    // one read beat as stored in the read FIFO
    typedef struct packed {
        logic [`HBMC_DATA_W-1:0] data;
        logic                    last;   // final beat of the burst
    } rdata_entry_t;

    typedef enum logic [1:0] {
        OKAY = 2'b00
    } axi_resp_t;

endpackage

`default_nettype wire

// File: verilog/hbmc_defines.svh
/* widths and sizes are fixed for a 32-bit AXI data path
   bursts are INCR only, up to 16 beats */
`ifndef HBMC_DEFINES_SVH
`define HBMC_DEFINES_SVH

`default_nettype none

`define HBMC_DATA_W      32
`define HBMC_STRB_W      4
`define HBMC_ID_W        4
`define HBMC_ADDR_W      12     // byte address, 4 KiB window
`define HBMC_WORD_ADDR_W 11
`define HBMC_MEM_WORDS   2048   // 16-bit words
`define HBMC_CNT_W       6      // up to 32 words per burst
`define HBMC_FIFO_DEPTH  16     // one full burst

`default_nettype wire

`endif
